// ==== src/rv_isa_pkg.sv ====
// RV32I instruction set definitions.
// Holds the opcode, funct3 and ALU operation encodings and the structs
// that carry a decoded operation and a register writeback between blocks.
package rv_isa_pkg;

    // major opcodes of the supported integer instructions.
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011, // register and register arithmetic.
        OPC_OP_IMM = 7'b0010011, // register and immediate arithmetic.
        OPC_LUI    = 7'b0110111  // load upper immediate.
    } opcode_e;

    // funct3 field values shared by the OP and OP-IMM groups.
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_e;

    localparam logic [6:0] F7_BASE = 7'b0000000; // normal form of an instruction.
    localparam logic [6:0] F7_ALT  = 7'b0100000; // selects SUB and SRA.

    // operations the execute stage knows how to perform.
    typedef enum logic [3:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
        OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU, OP_LUI
    } alu_op_e;

    typedef struct packed {
        logic        valid;   // word is a supported instruction.
        alu_op_e     op;      // operation for the ALU.
        logic [4:0]  rd;      // destination register.
        logic [4:0]  rs1;     // first source register.
        logic [4:0]  rs2;     // second source register.
        logic        use_imm; // second operand comes from imm and not rs2.
        logic [31:0] imm;     // immediate, already extended or shifted.
    } dec_op_t;

    typedef struct packed {
        logic        en;   // one cycle pulse per retired instruction.
        logic [4:0]  rd;   // register being written.
        logic [31:0] data; // value being written.
    } wb_t;

endpackage

// ==== src/apb_pkg.sv ====
// APB bus definitions for the host port.
// Request and response groups and the register map seen by the host.
package apb_pkg;

    typedef struct packed {
        logic        psel;    // slave is selected.
        logic        penable; // high in the access phase.
        logic        pwrite;  // write when high and read when low.
        logic [11:0] paddr;   // byte address.
        logic [31:0] pwdata;  // write data.
    } apb_req_t;

    typedef struct packed {
        logic        pready;  // transfer completes this cycle.
        logic [31:0] prdata;  // read data.
        logic        pslverr; // transfer failed.
    } apb_rsp_t;

    localparam logic [11:0] ADDR_INSTR  = 12'h000; // instruction register, write only.
    localparam logic [11:0] ADDR_STATUS = 12'h004; // retired and illegal counts, read only.
    localparam logic [11:0] ADDR_REGS   = 12'h080; // base of the register window.

endpackage

// ==== src/rv_decoder.sv ====
// RV32I decoder for the integer execute path.
// Turns an instruction word into a decoded ALU operation and flags words
// that are not supported or that name a register the file does not hold.
`timescale 1ns/1ps

module rv_decoder import rv_isa_pkg::*; #(
    parameter int NUM_REGS = 32
) (
    input  logic [31:0] instr,
    output dec_op_t     dec,
    output logic        illegal
);

    opcode_e     opc;
    funct3_e     f3;
    logic [6:0]  f7;
    logic [31:0] imm_i;   // sign-extended I-type immediate.
    logic [31:0] imm_sh;  // shift amount from the rs2 field.
    logic        rd_ok;
    logic        rs1_ok;
    logic        rs2_ok;
    logic        enc_ok;  // opcode, funct3 and funct7 form a supported encoding.
    logic        regs_ok; // every register the instruction uses exists.

    assign opc    = opcode_e'(instr[6:0]);
    assign f3     = funct3_e'(instr[14:12]);
    assign f7     = instr[31:25];
    assign imm_i  = {{20{instr[31]}}, instr[31:20]};
    assign imm_sh = {27'b0, instr[24:20]};
    assign rd_ok  = int'(instr[11:7]) < NUM_REGS;
    assign rs1_ok = int'(instr[19:15]) < NUM_REGS;
    assign rs2_ok = int'(instr[24:20]) < NUM_REGS;

    always_comb begin
        dec     = '0;
        dec.op  = OP_ADD;
        dec.rd  = instr[11:7];
        dec.rs1 = instr[19:15];
        dec.rs2 = instr[24:20];
        enc_ok  = 1'b0;
        regs_ok = 1'b0;
        case (opc)
            OPC_OP: begin
                regs_ok = rd_ok && rs1_ok && rs2_ok;
                enc_ok  = (f7 == F7_BASE) ||
                          ((f7 == F7_ALT) && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA));
                case (f3)
                    F3_ADD_SUB: dec.op = (f7 == F7_ALT) ? OP_SUB : OP_ADD;
                    F3_SLL:     dec.op = OP_SLL;
                    F3_SLT:     dec.op = OP_SLT;
                    F3_SLTU:    dec.op = OP_SLTU;
                    F3_XOR:     dec.op = OP_XOR;
                    F3_SRL_SRA: dec.op = (f7 == F7_ALT) ? OP_SRA : OP_SRL;
                    F3_OR:      dec.op = OP_OR;
                    F3_AND:     dec.op = OP_AND;
                    default:    dec.op = OP_ADD;
                endcase
            end
            OPC_OP_IMM: begin
                regs_ok     = rd_ok && rs1_ok;
                enc_ok      = 1'b1;           // no funct7 check outside the shifts.
                dec.use_imm = 1'b1;
                dec.imm     = imm_i;
                case (f3)
                    F3_ADD_SUB: dec.op = OP_ADD;  // ADDI has no SUBI form.
                    F3_SLL: begin
                        dec.op  = OP_SLL;
                        dec.imm = imm_sh;
                        enc_ok  = (f7 == F7_BASE);
                    end
                    F3_SLT:     dec.op = OP_SLT;
                    F3_SLTU:    dec.op = OP_SLTU; // compares against the sign-extended value.
                    F3_XOR:     dec.op = OP_XOR;
                    F3_SRL_SRA: begin
                        dec.op  = (f7 == F7_ALT) ? OP_SRA : OP_SRL;
                        dec.imm = imm_sh;
                        enc_ok  = (f7 == F7_BASE) || (f7 == F7_ALT);
                    end
                    F3_OR:      dec.op = OP_OR;
                    F3_AND:     dec.op = OP_AND;
                    default:    dec.op = OP_ADD;
                endcase
            end
            OPC_LUI: begin
                regs_ok     = rd_ok;          // upper bits are immediate, no sources.
                enc_ok      = 1'b1;
                dec.op      = OP_LUI;
                dec.use_imm = 1'b1;
                dec.imm     = {instr[31:12], 12'b0};
            end
            default: enc_ok = 1'b0;           // any other opcode is unsupported.
        endcase
        dec.valid = enc_ok && regs_ok;
    end

    assign illegal = !dec.valid;

endmodule

// ==== src/rv_regfile.sv ====
// Integer register file.
// Two operand read ports, a third read port for the host window and one
// writeback port. Register x0 always reads as zero.
`timescale 1ns/1ps

module rv_regfile import rv_isa_pkg::*; #(
    parameter int NUM_REGS = 32
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data,
    input  logic [4:0]  raddr,
    output logic [31:0] rdata,
    input  wb_t         wb
);

    logic [31:0] regs [NUM_REGS]; // architectural registers.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && wb.rd != 5'd0 && int'(wb.rd) < NUM_REGS) begin
            regs[wb.rd] <= wb.data; // x0 and missing registers are never written.
        end
    end

    // reads of x0 or of an index beyond the file return zero.
    assign rs1_data = (rs1 != 5'd0 && int'(rs1) < NUM_REGS) ? regs[rs1] : '0;
    assign rs2_data = (rs2 != 5'd0 && int'(rs2) < NUM_REGS) ? regs[rs2] : '0;
    assign rdata    = (raddr != 5'd0 && int'(raddr) < NUM_REGS) ? regs[raddr] : '0;

endmodule

// ==== src/ex_alu.sv ====
// Integer execute unit.
// Computes the result of one decoded operation and registers it together
// with the destination, so the writeback appears one cycle after issue.
`timescale 1ns/1ps

module ex_alu import rv_isa_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        issue,
    input  dec_op_t     dec,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    output wb_t         wb
);

    logic [31:0] op_b;     // second operand after the immediate select.
    logic [4:0]  shamt;    // shift amount from the low operand bits.
    logic [31:0] result;   // combinational result of the current operation.
    logic        capture;  // a supported instruction is issued this cycle.
    logic        en_q;
    logic [4:0]  rd_q;
    logic [31:0] data_q;

    assign op_b    = dec.use_imm ? dec.imm : rs2_data;
    assign shamt   = op_b[4:0];       // register shifts take their amount from rs2.
    assign capture = issue && dec.valid;

    always_comb begin
        case (dec.op)
            OP_ADD:  result = rs1_data + op_b;
            OP_SUB:  result = rs1_data - op_b;
            OP_AND:  result = rs1_data & op_b;
            OP_OR:   result = rs1_data | op_b;
            OP_XOR:  result = rs1_data ^ op_b;
            OP_SLL:  result = rs1_data << shamt;
            OP_SRL:  result = rs1_data >> shamt;
            OP_SRA:  result = $unsigned($signed(rs1_data) >>> shamt); // sign fills from the top.
            OP_SLT:  result = {31'b0, $signed(rs1_data) < $signed(op_b)};
            OP_SLTU: result = {31'b0, rs1_data < op_b}; // SLTIU sees the sign-extended immediate.
            OP_LUI:  result = op_b;         // the decoder already placed the upper bits.
            default: result = '0;
        endcase
    end

    // enable is control state and clears on reset.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            en_q <= 1'b0;
        end else begin
            en_q <= capture;               // high for exactly one cycle per instruction.
        end
    end

    // result and destination only load when an instruction is taken.
    always_ff @(posedge clk) begin
        if (capture) begin
            rd_q   <= dec.rd;
            data_q <= result;
        end
    end

    always_comb begin
        wb.en   = en_q;
        wb.rd   = rd_q;
        wb.data = data_q;
    end

endmodule

// ==== src/apb_issue_port.sv ====
// APB slave in front of the execute path.
// Issues instruction words written to the instruction register, serves
// register window and status reads, and counts retired and illegal
// instructions in two saturating counters.
`timescale 1ns/1ps

module apb_issue_port import rv_isa_pkg::*, apb_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  apb_req_t    apb_req,
    output apb_rsp_t    apb_rsp,
    input  logic        illegal,
    input  wb_t         wb,
    output logic [31:0] instr,
    output logic        issue,
    output logic [4:0]  raddr,
    input  logic [31:0] rdata
);

    logic        access;      // access phase of any transfer.
    logic        wr_acc;
    logic        rd_acc;
    logic        hit_instr;
    logic        hit_status;
    logic        hit_regs;    // address falls in the register window.
    logic [15:0] retired_cnt;
    logic [15:0] illegal_cnt;

    assign access     = apb_req.psel && apb_req.penable;
    assign wr_acc     = access && apb_req.pwrite;
    assign rd_acc     = access && !apb_req.pwrite;
    assign hit_instr  = apb_req.paddr == ADDR_INSTR;
    assign hit_status = apb_req.paddr == ADDR_STATUS;
    assign hit_regs   = (apb_req.paddr[11:7] == ADDR_REGS[11:7]) && (apb_req.paddr[1:0] == 2'b00);

    assign issue = wr_acc && hit_instr;     // one cycle per instruction write.
    assign instr = apb_req.pwdata;          // the word goes straight to the decoder.
    assign raddr = apb_req.paddr[6:2];      // word index inside the window.

    always_comb begin
        apb_rsp.pready = 1'b1;               // no wait states.
        apb_rsp.prdata = '0;
        if (rd_acc && hit_status) begin
            apb_rsp.prdata = {retired_cnt, illegal_cnt};
        end else if (rd_acc && hit_regs) begin
            apb_rsp.prdata = rdata;
        end
        // bad writes, illegal words and reads outside the map all fail.
        apb_rsp.pslverr = (wr_acc && (!hit_instr || illegal)) ||
                          (rd_acc && !(hit_status || hit_regs));
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            retired_cnt <= '0;
            illegal_cnt <= '0;
        end else begin
            if (wb.en && retired_cnt != 16'hffff) begin
                retired_cnt <= retired_cnt + 16'd1; // counts on the writeback pulse.
            end
            if (issue && illegal && illegal_cnt != 16'hffff) begin
                illegal_cnt <= illegal_cnt + 16'd1;
            end
        end
    end

endmodule

// ==== src/alu_core_top.sv ====
// Top level of the APB driven integer execute core.
// Connects the host port, decoder, register file and ALU, and sets the
// register count for the whole core.
`timescale 1ns/1ps

module alu_core_top import rv_isa_pkg::*, apb_pkg::*; #(
    parameter int NUM_REGS = 32
) (
    input  logic     clk,
    input  logic     rst,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);

    logic [31:0] instr;    // word under decode.
    logic        issue;    // instruction write in its access phase.
    logic        illegal;
    dec_op_t     dec;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [4:0]  raddr;    // host window read index.
    logic [31:0] rdata;
    wb_t         wb;

    apb_issue_port u_port (
        .clk(clk), .rst(rst), .apb_req(apb_req), .apb_rsp(apb_rsp),
        .illegal(illegal), .wb(wb), .instr(instr), .issue(issue),
        .raddr(raddr), .rdata(rdata)
    );

    rv_decoder #(.NUM_REGS(NUM_REGS)) u_dec (
        .instr(instr), .dec(dec), .illegal(illegal)
    );

    rv_regfile #(.NUM_REGS(NUM_REGS)) u_rf (
        .clk(clk), .rst(rst), .rs1(dec.rs1), .rs2(dec.rs2),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .raddr(raddr), .rdata(rdata), .wb(wb)
    );

    ex_alu u_alu (
        .clk(clk), .rst(rst), .issue(issue), .dec(dec),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .wb(wb)
    );

endmodule

// ==== testbench/alu_core_properties.sv ====
// Timing rules of the execute core.
// Watches the writeback pulse against accepted instruction writes and
// the APB ready line, and is bound into the top level.
`timescale 1ns/1ps

module alu_core_properties import rv_isa_pkg::*, apb_pkg::*; (
    input logic     clk,
    input logic     rst,
    input apb_req_t apb_req,
    input apb_rsp_t apb_rsp,
    input wb_t      wb
);

    logic instr_done; // an instruction write completes without an error.

    assign instr_done = apb_req.psel && apb_req.penable && apb_req.pwrite &&
                        (apb_req.paddr == ADDR_INSTR) && apb_rsp.pready && !apb_rsp.pslverr;

    // one instruction retires in exactly one cycle.
    wb_single_cycle: assert property (@(posedge clk) disable iff (rst) wb.en |=> !wb.en)
        else $error("writeback enable stayed high for two cycles");

    // an accepted instruction write is always followed by its writeback.
    wb_after_issue: assert property (@(posedge clk) disable iff (rst) instr_done |=> wb.en)
        else $error("no writeback in the cycle after an accepted instruction write");

    pready_always_high: assert property (@(posedge clk) apb_rsp.pready) // no wait states.
        else $error("pready dropped low");

endmodule

bind alu_core_top alu_core_properties u_props (
    .clk(clk), .rst(rst), .apb_req(apb_req), .apb_rsp(apb_rsp), .wb(wb)
);

// ==== testbench/tb_alu_core.sv ====
// Testbench for the APB driven integer execute core.
// Applies a table of instruction words over APB, reads back the register
// window and the status word, and compares them with its own RV32I model.
`timescale 1ns/1ps

module tb_alu_core import rv_isa_pkg::*, apb_pkg::*;;

    localparam int CLK_PERIOD = 100;

    typedef struct packed {
        logic [31:0] instr; // word written to the instruction register.
        logic [4:0]  rd;    // register read back after the write.
        logic        bad;   // word is illegal and must return pslverr.
    } test_row_t;

    logic        clk = 1'b0;
    logic        rst;
    apb_req_t    req;
    apb_rsp_t    rsp;
    test_row_t   rows[$];          // stimulus table.
    logic [31:0] model_regs [32];  // expected architectural state.
    integer      seed;
    bit          table_built = 1'b0;
    int          checks = 0;
    int          errors = 0;

    alu_core_top #(.NUM_REGS(32)) dut0 (.clk(clk), .rst(rst), .apb_req(req), .apb_rsp(rsp));

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    function automatic logic [31:0] r_type(logic [6:0] f7, funct3_e f3, logic [4:0] rd,
                                           logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(logic [11:0] imm, funct3_e f3, logic [4:0] rd,
                                           logic [4:0] rs1);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] lui(logic [19:0] upper, logic [4:0] rd);
        return {upper, rd, OPC_LUI};
    endfunction

    task automatic add_row(logic [31:0] instr, logic bad);
        rows.push_back({instr, instr[11:7], bad}); // rd sits in bits 11 to 7 for every form used.
    endtask

    // result of a legal word from the RV32I rules and the model state.
    function automatic logic [31:0] model_result(logic [31:0] w);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic        alt;
        a   = model_regs[w[19:15]];
        alt = w[30];                                     // funct7 bit of SUB and SRA.
        if (w[6:0] == OPC_LUI) begin
            return {w[31:12], 12'h000};
        end
        b = (w[6:0] == OPC_OP_IMM) ? {{20{w[31]}}, w[31:20]} : model_regs[w[24:20]];
        case (w[14:12])
            3'd0: r = (w[6:0] == OPC_OP && alt) ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: r = (a < b) ? 32'd1 : 32'd0;           // unsigned, even for a negative immediate.
            3'd4: r = a ^ b;
            3'd5: r = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error: %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    // setup, access and one idle cycle.
    task automatic apb_write(logic [11:0] addr, logic [31:0] data, output logic err);
        @(posedge clk);
        req.psel    <= 1'b1;
        req.penable <= 1'b0;
        req.pwrite  <= 1'b1;
        req.paddr   <= addr;
        req.pwdata  <= data;
        @(posedge clk);
        req.penable <= 1'b1;
        do @(negedge clk); while (!rsp.pready); // the watchdog ends a stuck transfer.
        err = rsp.pslverr;
        @(posedge clk);
        req.psel    <= 1'b0;
        req.penable <= 1'b0;
    endtask

    task automatic apb_read(logic [11:0] addr, output logic [31:0] data, output logic err);
        @(posedge clk);
        req.psel    <= 1'b1;
        req.penable <= 1'b0;
        req.pwrite  <= 1'b0;
        req.paddr   <= addr;
        @(posedge clk);
        req.penable <= 1'b1;
        do @(negedge clk); while (!rsp.pready);
        data = rsp.prdata;
        err  = rsp.pslverr;
        @(posedge clk);
        req.psel    <= 1'b0;
        req.penable <= 1'b0;
    endtask

    task automatic build_table();
        logic [31:0] r;
        r = next_random();
        add_row(lui(r[31:12], 5'd1), 1'b0);
        add_row(i_type(12'(next_random()), F3_ADD_SUB, 5'd1, 5'd1), 1'b0);
        r = next_random();
        add_row(lui({1'b1, r[18:0]}, 5'd2), 1'b0);                  // x2 is negative.
        add_row(i_type(12'(next_random()), F3_ADD_SUB, 5'd2, 5'd2), 1'b0);
        add_row(i_type(12'(next_random()), F3_ADD_SUB, 5'd3, 5'd0), 1'b0);
        r = next_random();
        add_row(lui({1'b0, r[18:0]}, 5'd4), 1'b0);                  // x4 is positive.
        add_row(r_type(F7_BASE, F3_ADD_SUB, 5'd5, 5'd1, 5'd2), 1'b0);
        add_row(r_type(F7_ALT, F3_ADD_SUB, 5'd6, 5'd1, 5'd2), 1'b0);
        add_row(r_type(F7_BASE, F3_AND, 5'd7, 5'd1, 5'd2), 1'b0);
        add_row(r_type(F7_BASE, F3_OR, 5'd8, 5'd1, 5'd2), 1'b0);
        add_row(r_type(F7_BASE, F3_XOR, 5'd9, 5'd1, 5'd2), 1'b0);
        add_row(r_type(F7_BASE, F3_SLT, 5'd10, 5'd1, 5'd2), 1'b0);
        add_row(r_type(F7_BASE, F3_SLTU, 5'd11, 5'd1, 5'd2), 1'b0);
        add_row(r_type(F7_BASE, F3_SLT, 5'd12, 5'd2, 5'd1), 1'b0);
        add_row(r_type(F7_BASE, F3_SLTU, 5'd13, 5'd2, 5'd1), 1'b0);
        add_row(i_type(12'(next_random()), F3_ADD_SUB, 5'd14, 5'd1), 1'b0);
        add_row(i_type(12'(next_random()), F3_AND, 5'd15, 5'd2), 1'b0);
        add_row(i_type(12'(next_random()), F3_OR, 5'd16, 5'd4), 1'b0);
        add_row(i_type(12'(next_random()), F3_XOR, 5'd17, 5'd1), 1'b0);
        add_row(i_type(12'(next_random()), F3_SLT, 5'd18, 5'd2), 1'b0);
        add_row(i_type(12'hfff, F3_SLTU, 5'd19, 5'd1), 1'b0);       // compares with all ones.
        add_row(i_type(12'h800, F3_SLTU, 5'd20, 5'd4), 1'b0);
        r = next_random();
        add_row(i_type({7'b0, r[4:0]}, F3_SLL, 5'd21, 5'd1), 1'b0);
        add_row(i_type({7'b0, r[9:5]}, F3_SRL_SRA, 5'd22, 5'd2), 1'b0);
        add_row(i_type({F7_ALT, r[14:10]}, F3_SRL_SRA, 5'd23, 5'd2), 1'b0);
        add_row(r_type(F7_BASE, F3_SLL, 5'd24, 5'd1, 5'd3), 1'b0);
        add_row(r_type(F7_BASE, F3_SRL_SRA, 5'd25, 5'd2, 5'd3), 1'b0);
        add_row(r_type(F7_ALT, F3_SRL_SRA, 5'd26, 5'd2, 5'd3), 1'b0);
        add_row(i_type(12'(next_random()), F3_ADD_SUB, 5'd0, 5'd1), 1'b0);
        add_row(r_type(F7_BASE, F3_ADD_SUB, 5'd0, 5'd1, 5'd2), 1'b0);
        r = next_random();
        add_row({r[31:12], 5'd5, 7'b1100011}, 1'b1);                 // branch opcode.
        add_row(r_type(F7_ALT, F3_AND, 5'd7, 5'd1, 5'd2), 1'b1);
        add_row(i_type({F7_ALT, 5'd3}, F3_SLL, 5'd21, 5'd1), 1'b1);
        add_row(r_type(7'b0000001, F3_ADD_SUB, 5'd8, 5'd1, 5'd2), 1'b1); // multiply form.
    endtask

    initial begin
        wait (table_built);
        #((rows.size() * 8 + 100) * CLK_PERIOD);
        $display("timeout: the run did not finish within the expected number of cycles");
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        logic [31:0] data;
        logic        err;
        int          n_legal;
        int          n_illegal;
        n_legal   = 0;
        n_illegal = 0;
        rst  = 1'b1;
        req  = '0;
        seed = 32'h2ca8_f2ce;
        foreach (model_regs[i]) model_regs[i] = '0;
        build_table();
        table_built = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        foreach (rows[i]) begin
            apb_write(ADDR_INSTR, rows[i].instr, err);
            check_value($sformatf("pslverr row %0d", i), 32'(err), 32'(rows[i].bad));
            if (rows[i].bad) begin
                n_illegal++;                                 // state must stay as it was.
            end else begin
                n_legal++;
                if (rows[i].rd != 5'd0) model_regs[rows[i].rd] = model_result(rows[i].instr);
            end
            apb_read(ADDR_REGS + 12'({rows[i].rd, 2'b00}), data, err);
            check_value($sformatf("prdata x%0d", rows[i].rd), data, model_regs[rows[i].rd]);
            check_value($sformatf("pslverr read x%0d", rows[i].rd), 32'(err), 32'd0);
        end
        apb_read(12'h008, data, err);                        // hole in the register map.
        check_value("pslverr unmapped read", 32'(err), 32'd1);
        apb_write(ADDR_STATUS, 32'h0, err);                  // status word is read only.
        check_value("pslverr status write", 32'(err), 32'd1);
        apb_read(ADDR_STATUS, data, err);
        check_value("prdata status", data, {16'(n_legal), 16'(n_illegal)});
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== project.f ====
src/rv_isa_pkg.sv
src/apb_pkg.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/ex_alu.sv
src/apb_issue_port.sv
src/alu_core_top.sv
testbench/alu_core_properties.sv
testbench/tb_alu_core.sv
